// ==== src.f ====
rtl/sonata_pkg.sv
rtl/test_ram.sv
rtl/led_status.sv
rtl/sonata_reg.sv
rtl/mem_rwtest.sv
rtl/sonata_top.sv
verif/tb_sonata_top.sv

// ==== verif/tb_sonata_top.sv ====
module tb_sonata_top import sonata_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ,       // read a register and compare
        OP_WAIT_IDLE,
        OP_LEDS        // compare usrled_o and status_led_o
    } step_op_e;

    typedef struct packed {
        step_op_e              op;
        reg_addr_e             addr;
        logic [REG_DATA_W-1:0] data;
        logic [15:0]           expected;   // leds use {status, usrled}
    } step_t;

    logic                    mainclk_buf = 1'b0;
    logic                    rst_i;
    logic [REG_ADDR_W-1:0]   reg_addr_i;
    logic [REG_DATA_W-1:0]   reg_wdata_i;
    logic                    reg_write_i;
    logic                    reg_read_i;
    logic [LED_W-1:0]        usrsw_i;
    logic [REG_DATA_W-1:0]   reg_rdata_o;
    logic [LED_W-1:0]        usrled_o;
    logic [STATUS_LED_W-1:0] status_led_o;

    step_t                 steps[$];
    logic [LED_W-1:0]      rnd_leds;
    logic [REG_DATA_W-1:0] rnd_status;
    logic [LED_W-1:0]      rnd_sw;

    always #5 mainclk_buf = ~mainclk_buf;

    sonata_top i_sonata_top (
        .mainclk_buf  (mainclk_buf),
        .rst_i        (rst_i),
        .reg_addr_i   (reg_addr_i),
        .reg_wdata_i  (reg_wdata_i),
        .reg_write_i  (reg_write_i),
        .reg_read_i   (reg_read_i),
        .usrsw_i      (usrsw_i),
        .reg_rdata_o  (reg_rdata_o),
        .usrled_o     (usrled_o),
        .status_led_o (status_led_o)
    );

    function automatic logic [REG_DATA_W-1:0] ctrl_bits(input logic start, input logic check,
                                                        input logic lfsr, input logic clear,
                                                        input logic manual);
        logic [REG_DATA_W-1:0] v;
        v                = '0;
        v[MT_START_BIT]  = start;
        v[MT_CHECK_BIT]  = check;
        v[MT_LFSR_BIT]   = lfsr;
        v[MT_CLEAR_BIT]  = clear;
        v[MT_MANUAL_BIT] = manual;
        return v;
    endfunction

    function automatic logic [15:0] status_bits(input logic idle, input logic pass,
                                                input logic fail);
        logic [15:0] v;
        v              = '0;
        v[ST_IDLE_BIT] = idle;
        v[ST_PASS_BIT] = pass;
        v[ST_FAIL_BIT] = fail;
        return v;
    endfunction

    function automatic logic [15:0] led_view(input logic [LED_W-1:0] usr,
                                             input logic [STATUS_LED_W-1:0] st);
        return 16'({st, usr});
    endfunction

    // reference lfsr that shifts left and xors the taps when the msb falls out
    function automatic logic [MEM_DATA_W-1:0] next_pattern(input logic [MEM_DATA_W-1:0] w);
        logic carry;
        carry = w[MEM_DATA_W-1];
        w     = w << 1;
        if (carry) begin
            w = w ^ LFSR_TAPS;
        end
        return w;
    endfunction

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_byte(input string what, input logic [REG_DATA_W-1:0] got,
                              input logic [REG_DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%02h, expected 0x%02h", what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_leds(input logic [LED_W-1:0] got_usr, input logic [LED_W-1:0] exp_usr,
                              input logic [STATUS_LED_W-1:0] got_st,
                              input logic [STATUS_LED_W-1:0] exp_st);
        if (got_usr !== exp_usr || got_st !== exp_st) begin
            $display("Fail usrled_o/status_led_o: got 0x%02h/0x%01h, expected 0x%02h/0x%01h",
                     got_usr, got_st, exp_usr, exp_st);
            abort_run();
        end
    endtask

    task automatic check_state(input logic [REG_DATA_W-1:0] got, input logic exp_idle,
                               input logic exp_pass, input logic exp_fail);
        logic [2:0] got_bits;
        logic [2:0] exp_bits;
        got_bits = {got[ST_IDLE_BIT], got[ST_FAIL_BIT], got[ST_PASS_BIT]};
        exp_bits = {exp_idle, exp_fail, exp_pass};
        if (got_bits !== exp_bits) begin
            $display("Fail reg_rdata_o idle/fail/pass: got 0x%01h, expected 0x%01h",
                     got_bits, exp_bits);
            abort_run();
        end
    endtask

    task automatic write_reg(input reg_addr_e a, input logic [REG_DATA_W-1:0] d);
        @(posedge mainclk_buf);
        reg_addr_i  <= a;
        reg_wdata_i <= d;
        reg_write_i <= 1'b1;
        @(posedge mainclk_buf);
        reg_write_i <= 1'b0;
    endtask

    task automatic read_reg(input reg_addr_e a, output logic [REG_DATA_W-1:0] d);
        @(posedge mainclk_buf);
        reg_addr_i <= a;
        reg_read_i <= 1'b1;
        @(posedge mainclk_buf);
        reg_read_i <= 1'b0;
        @(negedge mainclk_buf);   // rdata settled
        d = reg_rdata_o;
    endtask

    task automatic wait_idle();
        logic [REG_DATA_W-1:0] st;
        int                    polls;
        st    = '0;
        polls = 0;
        while (!st[ST_IDLE_BIT]) begin
            if (polls == 2000) begin   // well above a full 256 word run
                $display("memory test did not return to idle within %0d status polls", polls);
                abort_run();
            end
            read_reg(REG_MT_STATUS, st);
            polls++;
        end
    endtask

    task automatic add_step(input step_op_e op, input reg_addr_e a,
                            input logic [REG_DATA_W-1:0] d, input logic [15:0] exp);
        steps.push_back('{op: op, addr: a, data: d, expected: exp});
    endtask

    task automatic queue_run(input logic [7:0] first, input logic [7:0] stop,
                             input logic [REG_DATA_W-1:0] ctrl);
        add_step(OP_WRITE, REG_MT_START, first, '0);
        add_step(OP_WRITE, REG_MT_STOP, stop, '0);
        add_step(OP_WRITE, REG_MT_CTRL, ctrl, '0);
        add_step(OP_WAIT_IDLE, REG_MT_STATUS, '0, '0);
    endtask

    task automatic build_table();
        logic [MEM_DATA_W-1:0] model_word;
        // state straight out of reset
        add_step(OP_READ, REG_MT_STATUS, '0, status_bits(1'b1, 1'b0, 1'b0));
        add_step(OP_LEDS, REG_LED_CTRL, '0, led_view('0, '0));
        add_step(OP_READ, REG_SWITCHES, '0, 16'(rnd_sw));
        // test, flash-all and user led views
        add_step(OP_WRITE, REG_TEST_LEDS, rnd_leds, '0);
        add_step(OP_WRITE, REG_TEST_STATUS, rnd_status, '0);
        add_step(OP_WRITE, REG_LED_CTRL, 8'(1 << LED_TEST_BIT), '0);
        add_step(OP_LEDS, REG_LED_CTRL, '0, led_view(rnd_leds, rnd_status[STATUS_LED_W-1:0]));
        add_step(OP_WRITE, REG_LED_CTRL, 8'((1 << LED_TEST_BIT) | (1 << LED_FLASH_BIT)), '0);
        add_step(OP_LEDS, REG_LED_CTRL, '0, led_view('0, '0));   // heartbeat still low
        add_step(OP_WRITE, REG_LED_CTRL, 8'(1 << LED_USER_BIT), '0);
        add_step(OP_LEDS, REG_LED_CTRL, '0, led_view(8'h10, '0));
        add_step(OP_WRITE, REG_LED_CTRL, '0, '0);
        // lfsr full run, then check-only over the same words
        queue_run(8'h00, 8'hFF, ctrl_bits(1'b1, 1'b0, 1'b1, 1'b0, 1'b0));
        add_step(OP_READ, REG_MT_STATUS, '0, status_bits(1'b1, 1'b1, 1'b0));
        add_step(OP_READ, REG_MT_ERRORS, '0, '0);
        queue_run(8'h00, 8'hFF, ctrl_bits(1'b1, 1'b1, 1'b1, 1'b0, 1'b0));
        add_step(OP_READ, REG_MT_STATUS, '0, status_bits(1'b1, 1'b1, 1'b0));
        // model lfsr words written by hand must match the engine sequence
        add_step(OP_WRITE, REG_MT_CTRL, ctrl_bits(1'b0, 1'b0, 1'b0, 1'b0, 1'b1), '0);
        model_word = LFSR_SEED;
        for (int i = 0; i < 4; i++) begin
            add_step(OP_WRITE, REG_MAN_ADDR, 8'(8'h10 + i), '0);
            add_step(OP_WRITE, REG_MAN_WDATA_LO, model_word[7:0], '0);
            add_step(OP_WRITE, REG_MAN_WDATA_HI, model_word[15:8], '0);
            model_word = next_pattern(model_word);
        end
        queue_run(8'h10, 8'h13, ctrl_bits(1'b1, 1'b1, 1'b1, 1'b0, 1'b0));
        add_step(OP_READ, REG_MT_STATUS, '0, status_bits(1'b1, 1'b1, 1'b0));
        // address mode full run
        queue_run(8'h10, 8'h3F, ctrl_bits(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
        add_step(OP_READ, REG_MT_STATUS, '0, status_bits(1'b1, 1'b1, 1'b0));
        add_step(OP_READ, REG_MT_ERRORS, '0, '0);
        add_step(OP_LEDS, REG_LED_CTRL, '0, led_view(8'h08, '0));   // pass led
        // corrupt one word by hand and catch it
        add_step(OP_WRITE, REG_MT_CTRL, ctrl_bits(1'b0, 1'b0, 1'b0, 1'b0, 1'b1), '0);
        add_step(OP_WRITE, REG_MAN_ADDR, 8'h22, '0);
        add_step(OP_WRITE, REG_MAN_WDATA_LO, 8'h00, '0);
        add_step(OP_WRITE, REG_MAN_WDATA_HI, 8'h55, '0);
        queue_run(8'h10, 8'h3F, ctrl_bits(1'b1, 1'b1, 1'b0, 1'b0, 1'b0));
        add_step(OP_READ, REG_MT_STATUS, '0, status_bits(1'b1, 1'b0, 1'b1));
        add_step(OP_READ, REG_MT_ERRORS, '0, 16'h0001);
        add_step(OP_READ, REG_MT_ERR_ADDR, '0, 16'h0022);
        add_step(OP_LEDS, REG_LED_CTRL, '0, led_view(8'h04, '0));   // fail led
        add_step(OP_WRITE, REG_MT_CTRL, ctrl_bits(1'b0, 1'b0, 1'b0, 1'b1, 1'b0), '0);
        add_step(OP_READ, REG_MT_STATUS, '0, status_bits(1'b1, 1'b0, 1'b0));
        // second start mid-run with a clean range that would pass if restarted
        add_step(OP_WRITE, REG_MT_START, 8'h20, '0);
        add_step(OP_WRITE, REG_MT_STOP, 8'h3F, '0);
        add_step(OP_WRITE, REG_MT_CTRL, ctrl_bits(1'b1, 1'b1, 1'b0, 1'b0, 1'b0), '0);
        add_step(OP_READ, REG_MT_STATUS, '0, status_bits(1'b0, 1'b0, 1'b0));
        add_step(OP_WRITE, REG_MT_START, 8'h30, '0);
        add_step(OP_WRITE, REG_MT_CTRL, ctrl_bits(1'b1, 1'b1, 1'b0, 1'b0, 1'b0), '0);
        add_step(OP_WAIT_IDLE, REG_MT_STATUS, '0, '0);
        add_step(OP_READ, REG_MT_STATUS, '0, status_bits(1'b1, 1'b0, 1'b1));
        add_step(OP_READ, REG_MT_ERRORS, '0, 16'h0001);
        add_step(OP_READ, REG_MT_ERR_ADDR, '0, 16'h0022);
        // empty range passes at once
        add_step(OP_WRITE, REG_MT_CTRL, ctrl_bits(1'b0, 1'b0, 1'b0, 1'b1, 1'b0), '0);
        queue_run(8'h20, 8'h10, ctrl_bits(1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
        add_step(OP_READ, REG_MT_STATUS, '0, status_bits(1'b1, 1'b1, 1'b0));
        add_step(OP_READ, REG_MT_ERRORS, '0, '0);
    endtask

    task automatic apply_step(input step_t s);
        logic [REG_DATA_W-1:0] rd;
        case (s.op)
            OP_WRITE: write_reg(s.addr, s.data);
            OP_READ: begin
                read_reg(s.addr, rd);
                if (s.addr == REG_MT_STATUS) begin
                    check_state(rd, s.expected[ST_IDLE_BIT], s.expected[ST_PASS_BIT],
                                s.expected[ST_FAIL_BIT]);
                end else begin
                    check_byte($sformatf("reg_rdata_o (%s)", s.addr.name()), rd,
                               s.expected[REG_DATA_W-1:0]);
                end
            end
            OP_WAIT_IDLE: wait_idle();
            default: begin
                @(negedge mainclk_buf);
                check_leds(usrled_o, s.expected[LED_W-1:0],
                           status_led_o, s.expected[LED_W +: STATUS_LED_W]);
            end
        endcase
    endtask

    initial begin
        rst_i       = 1'b1;
        reg_addr_i  = '0;
        reg_wdata_i = '0;
        reg_write_i = 1'b0;
        reg_read_i  = 1'b0;
        void'($urandom(32'h1857_9c36));
        rnd_leds   = LED_W'($urandom());
        rnd_status = REG_DATA_W'($urandom());   // upper nibble is dropped by the register
        rnd_sw     = LED_W'($urandom());
        usrsw_i    = rnd_sw;
        build_table();
        repeat (10) @(posedge mainclk_buf);
        rst_i <= 1'b0;
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== rtl/sonata_top.sv ====
module sonata_top import sonata_pkg::*; (
    input  logic                    mainclk_buf,
    input  logic                    rst_i,
    input  logic [REG_ADDR_W-1:0]   reg_addr_i,
    input  logic [REG_DATA_W-1:0]   reg_wdata_i,
    input  logic                    reg_write_i,
    input  logic                    reg_read_i,
    input  logic [LED_W-1:0]        usrsw_i,
    output logic [REG_DATA_W-1:0]   reg_rdata_o,
    output logic [LED_W-1:0]        usrled_o,
    output logic [STATUS_LED_W-1:0] status_led_o
);

    logic                    led_test;
    logic                    led_flash;
    logic                    user_led;
    logic [LED_W-1:0]        test_leds;
    logic [STATUS_LED_W-1:0] test_status;

    // register block to test engine
    logic                  mt_start;
    logic                  mt_clear;
    logic                  mt_check;
    logic                  mt_lfsr;
    logic                  mt_manual;
    logic [MEM_ADDR_W-1:0] mt_addr_start;
    logic [MEM_ADDR_W-1:0] mt_addr_stop;
    logic                  man_we;
    logic [MEM_ADDR_W-1:0] man_addr;
    logic [MEM_DATA_W-1:0] man_wdata;

    // test engine results
    logic                  mt_pass;
    logic                  mt_fail;
    logic                  mt_idle;
    logic [ERR_CNT_W-1:0]  mt_errors;
    logic [MEM_ADDR_W-1:0] mt_err_addr;

    logic                  ram_we;
    logic [MEM_ADDR_W-1:0] ram_addr;
    logic [MEM_DATA_W-1:0] ram_wdata;
    logic [MEM_DATA_W-1:0] ram_rdata;

    sonata_reg i_sonata_reg (
        .mainclk_buf     (mainclk_buf),
        .rst_i           (rst_i),
        .reg_addr_i      (reg_addr_i),
        .reg_wdata_i     (reg_wdata_i),
        .reg_write_i     (reg_write_i),
        .reg_read_i      (reg_read_i),
        .usrsw_i         (usrsw_i),
        .mt_pass_i       (mt_pass),
        .mt_fail_i       (mt_fail),
        .mt_idle_i       (mt_idle),
        .mt_errors_i     (mt_errors),
        .mt_err_addr_i   (mt_err_addr),
        .reg_rdata_o     (reg_rdata_o),
        .led_test_o      (led_test),
        .led_flash_o     (led_flash),
        .user_led_o      (user_led),
        .test_leds_o     (test_leds),
        .test_status_o   (test_status),
        .mt_start_o      (mt_start),
        .mt_clear_o      (mt_clear),
        .mt_check_o      (mt_check),
        .mt_lfsr_o       (mt_lfsr),
        .mt_manual_o     (mt_manual),
        .mt_addr_start_o (mt_addr_start),
        .mt_addr_stop_o  (mt_addr_stop),
        .man_we_o        (man_we),
        .man_addr_o      (man_addr),
        .man_wdata_o     (man_wdata)
    );

    mem_rwtest i_mem_rwtest (
        .mainclk_buf   (mainclk_buf),
        .rst_i         (rst_i),
        .start_i       (mt_start),
        .clear_i       (mt_clear),
        .check_only_i  (mt_check),
        .lfsr_mode_i   (mt_lfsr),
        .manual_i      (mt_manual),
        .addr_start_i  (mt_addr_start),
        .addr_stop_i   (mt_addr_stop),
        .man_we_i      (man_we),
        .man_addr_i    (man_addr),
        .man_wdata_i   (man_wdata),
        .ram_rdata_i   (ram_rdata),
        .ram_we_o      (ram_we),
        .ram_addr_o    (ram_addr),
        .ram_wdata_o   (ram_wdata),
        .pass_o        (mt_pass),
        .fail_o        (mt_fail),
        .idle_o        (mt_idle),
        .error_count_o (mt_errors),
        .error_addr_o  (mt_err_addr)
    );

    // on-chip stand-in for the hyperram
    test_ram i_test_ram (
        .mainclk_buf (mainclk_buf),
        .we_i        (ram_we),
        .addr_i      (ram_addr),
        .wdata_i     (ram_wdata),
        .rdata_o     (ram_rdata)
    );

    led_status i_led_status (
        .mainclk_buf   (mainclk_buf),
        .rst_i         (rst_i),
        .led_test_i    (led_test),
        .led_flash_i   (led_flash),
        .user_led_i    (user_led),
        .test_leds_i   (test_leds),
        .test_status_i (test_status),
        .mt_idle_i     (mt_idle),
        .mt_pass_i     (mt_pass),
        .mt_fail_i     (mt_fail),
        .usrled_o      (usrled_o),
        .status_led_o  (status_led_o)
    );

endmodule

// ==== rtl/mem_rwtest.sv ====
module mem_rwtest import sonata_pkg::*; (
    input  logic                  mainclk_buf,
    input  logic                  rst_i,
    input  logic                  start_i,
    input  logic                  clear_i,
    input  logic                  check_only_i,
    input  logic                  lfsr_mode_i,
    input  logic                  manual_i,
    input  logic [MEM_ADDR_W-1:0] addr_start_i,
    input  logic [MEM_ADDR_W-1:0] addr_stop_i,
    input  logic                  man_we_i,
    input  logic [MEM_ADDR_W-1:0] man_addr_i,
    input  logic [MEM_DATA_W-1:0] man_wdata_i,
    input  logic [MEM_DATA_W-1:0] ram_rdata_i,
    output logic                  ram_we_o,
    output logic [MEM_ADDR_W-1:0] ram_addr_o,
    output logic [MEM_DATA_W-1:0] ram_wdata_o,
    output logic                  pass_o,
    output logic                  fail_o,
    output logic                  idle_o,
    output logic [ERR_CNT_W-1:0]  error_count_o,
    output logic [MEM_ADDR_W-1:0] error_addr_o
);

    mt_state_e             state;
    logic [MEM_ADDR_W-1:0] addr;
    logic [MEM_ADDR_W-1:0] cmp_addr;
    logic [MEM_DATA_W-1:0] lfsr;
    logic [MEM_DATA_W-1:0] cmp_lfsr;
    logic [MEM_DATA_W-1:0] pattern;
    logic [MEM_DATA_W-1:0] expected;
    logic                  cmp_valid;
    logic                  last;
    logic                  mismatch;
    logic                  manual_path;

    // shift left, fold taps back in when a one falls out
    function automatic logic [MEM_DATA_W-1:0] lfsr_step(input logic [MEM_DATA_W-1:0] w);
        logic [MEM_DATA_W-1:0] shifted;
        shifted = {w[MEM_DATA_W-2:0], 1'b0};
        return w[MEM_DATA_W-1] ? (shifted ^ LFSR_TAPS) : shifted;
    endfunction

    assign idle_o      = (state == MT_IDLE);
    assign last        = (addr == addr_stop_i);
    assign pattern     = lfsr_mode_i ? lfsr : MEM_DATA_W'(addr);
    assign expected    = lfsr_mode_i ? cmp_lfsr : MEM_DATA_W'(cmp_addr);
    assign mismatch    = cmp_valid && (ram_rdata_i != expected);

    // host owns the ram port only in manual mode while idle
    assign manual_path = idle_o && manual_i;
    assign ram_we_o    = manual_path ? man_we_i : (state == MT_WRITE);
    assign ram_addr_o  = manual_path ? man_addr_i : addr;
    assign ram_wdata_o = manual_path ? man_wdata_i : pattern;

    always_ff @(posedge mainclk_buf) begin
        if (rst_i) begin
            state  <= MT_IDLE;
            addr   <= '0;
            lfsr   <= LFSR_SEED;
            pass_o <= 1'b0;
            fail_o <= 1'b0;
        end else begin
            case (state)
                MT_IDLE: begin
                    if (start_i) begin
                        addr   <= addr_start_i;
                        lfsr   <= LFSR_SEED;
                        pass_o <= 1'b0;
                        if (addr_stop_i < addr_start_i) begin
                            state <= MT_DONE;   // empty range
                        end else if (check_only_i) begin
                            state <= MT_READ;
                        end else begin
                            state <= MT_WRITE;
                        end
                    end
                end
                MT_WRITE: begin
                    if (last) begin
                        state <= MT_READ;
                        addr  <= addr_start_i;
                    end else begin
                        addr <= addr + 1'b1;
                        lfsr <= lfsr_step(lfsr);
                    end
                end
                MT_READ: begin
                    if (last) begin
                        state <= MT_DONE;
                    end else begin
                        addr <= addr + 1'b1;
                    end
                end
                MT_DONE: begin
                    // final compare lands in this cycle
                    state  <= MT_IDLE;
                    pass_o <= (error_count_o == '0) && !mismatch;
                    if ((error_count_o != '0) || mismatch) begin
                        fail_o <= 1'b1;
                    end
                end
                default: state <= MT_IDLE;
            endcase
            if (clear_i) begin
                fail_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge mainclk_buf) begin
        cmp_addr <= addr;   // address of the word now in flight
    end

    // compare stage, second lfsr one cycle behind the reads
    always_ff @(posedge mainclk_buf) begin
        if (rst_i) begin
            cmp_valid     <= 1'b0;
            cmp_lfsr      <= LFSR_SEED;
            error_count_o <= '0;
            error_addr_o  <= '0;
        end else begin
            cmp_valid <= (state == MT_READ);
            cmp_lfsr  <= cmp_valid ? lfsr_step(cmp_lfsr) : LFSR_SEED;
            if (idle_o && start_i) begin
                error_count_o <= '0;
                error_addr_o  <= '0;
            end else if (mismatch) begin
                if (error_count_o == '0) begin
                    error_addr_o <= cmp_addr;   // first error only
                end
                if (error_count_o != '1) begin
                    error_count_o <= error_count_o + 1'b1;   // saturate
                end
            end
        end
    end

endmodule

// ==== rtl/sonata_reg.sv ====
module sonata_reg import sonata_pkg::*; (
    input  logic                    mainclk_buf,
    input  logic                    rst_i,
    input  logic [REG_ADDR_W-1:0]   reg_addr_i,
    input  logic [REG_DATA_W-1:0]   reg_wdata_i,
    input  logic                    reg_write_i,
    input  logic                    reg_read_i,
    input  logic [LED_W-1:0]        usrsw_i,
    input  logic                    mt_pass_i,
    input  logic                    mt_fail_i,
    input  logic                    mt_idle_i,
    input  logic [ERR_CNT_W-1:0]    mt_errors_i,
    input  logic [MEM_ADDR_W-1:0]   mt_err_addr_i,
    output logic [REG_DATA_W-1:0]   reg_rdata_o,
    output logic                    led_test_o,
    output logic                    led_flash_o,
    output logic                    user_led_o,
    output logic [LED_W-1:0]        test_leds_o,
    output logic [STATUS_LED_W-1:0] test_status_o,
    output logic                    mt_start_o,
    output logic                    mt_clear_o,
    output logic                    mt_check_o,
    output logic                    mt_lfsr_o,
    output logic                    mt_manual_o,
    output logic [MEM_ADDR_W-1:0]   mt_addr_start_o,
    output logic [MEM_ADDR_W-1:0]   mt_addr_stop_o,
    output logic                    man_we_o,
    output logic [MEM_ADDR_W-1:0]   man_addr_o,
    output logic [MEM_DATA_W-1:0]   man_wdata_o
);

    reg_addr_e             addr;
    logic [REG_DATA_W-1:0] rdata_nxt;

    assign addr = reg_addr_e'(reg_addr_i);

    // host writes; pulses last exactly one cycle
    always_ff @(posedge mainclk_buf) begin
        if (rst_i) begin
            led_test_o      <= 1'b0;
            led_flash_o     <= 1'b0;
            user_led_o      <= 1'b0;
            test_leds_o     <= '0;
            test_status_o   <= '0;
            mt_start_o      <= 1'b0;
            mt_clear_o      <= 1'b0;
            mt_check_o      <= 1'b0;
            mt_lfsr_o       <= 1'b0;
            mt_manual_o     <= 1'b0;
            mt_addr_start_o <= '0;
            mt_addr_stop_o  <= '0;
            man_we_o        <= 1'b0;
            man_addr_o      <= '0;
            man_wdata_o     <= '0;
        end else begin
            mt_start_o <= 1'b0;
            mt_clear_o <= 1'b0;
            man_we_o   <= 1'b0;
            if (reg_write_i) begin
                case (addr)
                    REG_LED_CTRL: begin
                        led_test_o  <= reg_wdata_i[LED_TEST_BIT];
                        led_flash_o <= reg_wdata_i[LED_FLASH_BIT];
                        user_led_o  <= reg_wdata_i[LED_USER_BIT];
                    end
                    REG_TEST_LEDS:   test_leds_o   <= reg_wdata_i[LED_W-1:0];
                    REG_TEST_STATUS: test_status_o <= reg_wdata_i[STATUS_LED_W-1:0];
                    REG_MT_CTRL: begin
                        mt_start_o  <= reg_wdata_i[MT_START_BIT];
                        mt_clear_o  <= reg_wdata_i[MT_CLEAR_BIT];
                        mt_check_o  <= reg_wdata_i[MT_CHECK_BIT];
                        mt_lfsr_o   <= reg_wdata_i[MT_LFSR_BIT];
                        mt_manual_o <= reg_wdata_i[MT_MANUAL_BIT];
                    end
                    REG_MT_START:     mt_addr_start_o <= reg_wdata_i[MEM_ADDR_W-1:0];
                    REG_MT_STOP:      mt_addr_stop_o  <= reg_wdata_i[MEM_ADDR_W-1:0];
                    REG_MAN_ADDR:     man_addr_o      <= reg_wdata_i[MEM_ADDR_W-1:0];
                    REG_MAN_WDATA_LO: man_wdata_o[REG_DATA_W-1:0] <= reg_wdata_i;
                    REG_MAN_WDATA_HI: begin
                        // high byte completes the word and fires the write
                        man_wdata_o[MEM_DATA_W-1:REG_DATA_W] <= reg_wdata_i;
                        man_we_o <= 1'b1;
                    end
                    default: ;   // read-only or unmapped
                endcase
            end
        end
    end

    always_comb begin
        rdata_nxt = '0;
        case (addr)
            REG_LED_CTRL: begin
                rdata_nxt[LED_TEST_BIT]  = led_test_o;
                rdata_nxt[LED_FLASH_BIT] = led_flash_o;
                rdata_nxt[LED_USER_BIT]  = user_led_o;
            end
            REG_TEST_LEDS:   rdata_nxt = REG_DATA_W'(test_leds_o);
            REG_TEST_STATUS: rdata_nxt = REG_DATA_W'(test_status_o);
            REG_SWITCHES:    rdata_nxt = REG_DATA_W'(usrsw_i);
            REG_MT_CTRL: begin
                rdata_nxt[MT_CHECK_BIT]  = mt_check_o;   // start/clear read 0
                rdata_nxt[MT_LFSR_BIT]   = mt_lfsr_o;
                rdata_nxt[MT_MANUAL_BIT] = mt_manual_o;
            end
            REG_MT_START: rdata_nxt = REG_DATA_W'(mt_addr_start_o);
            REG_MT_STOP:  rdata_nxt = REG_DATA_W'(mt_addr_stop_o);
            REG_MT_STATUS: begin
                rdata_nxt[ST_PASS_BIT] = mt_pass_i;
                rdata_nxt[ST_FAIL_BIT] = mt_fail_i;
                rdata_nxt[ST_IDLE_BIT] = mt_idle_i;
            end
            REG_MT_ERRORS:    rdata_nxt = REG_DATA_W'(mt_errors_i);
            REG_MT_ERR_ADDR:  rdata_nxt = REG_DATA_W'(mt_err_addr_i);
            REG_MAN_ADDR:     rdata_nxt = REG_DATA_W'(man_addr_o);
            REG_MAN_WDATA_LO: rdata_nxt = man_wdata_o[REG_DATA_W-1:0];
            REG_MAN_WDATA_HI: rdata_nxt = man_wdata_o[MEM_DATA_W-1:REG_DATA_W];
            default:          rdata_nxt = '0;
        endcase
    end

    // read data holds until the next read strobe
    always_ff @(posedge mainclk_buf) begin
        if (rst_i) begin
            reg_rdata_o <= '0;
        end else if (reg_read_i) begin
            reg_rdata_o <= rdata_nxt;
        end
    end

endmodule

// ==== rtl/led_status.sv ====
module led_status import sonata_pkg::*; (
    input  logic                    mainclk_buf,
    input  logic                    rst_i,
    input  logic                    led_test_i,
    input  logic                    led_flash_i,
    input  logic                    user_led_i,
    input  logic [LED_W-1:0]        test_leds_i,
    input  logic [STATUS_LED_W-1:0] test_status_i,
    input  logic                    mt_idle_i,
    input  logic                    mt_pass_i,
    input  logic                    mt_fail_i,
    output logic [LED_W-1:0]        usrled_o,
    output logic [STATUS_LED_W-1:0] status_led_o
);

    logic [HEARTBEAT_W-1:0] heartbeat;
    logic                   hb;

    always_ff @(posedge mainclk_buf) begin
        if (rst_i) begin
            heartbeat <= '0;
        end else begin
            heartbeat <= heartbeat + 1'b1;
        end
    end

    assign hb = heartbeat[HEARTBEAT_W-1];   // slow blink

    always_comb begin
        usrled_o     = '0;
        status_led_o = '0;
        if (led_test_i && led_flash_i) begin
            usrled_o     = {LED_W{hb}};
            status_led_o = {STATUS_LED_W{hb}};
        end else if (led_test_i) begin
            usrled_o     = test_leds_i;
            status_led_o = test_status_i;
        end else begin
            // normal view, upper bits stay dark
            usrled_o[0] = hb;
            usrled_o[1] = ~mt_idle_i;   // engine busy
            usrled_o[2] = mt_fail_i;
            usrled_o[3] = mt_pass_i;
            usrled_o[4] = user_led_i;
        end
    end

endmodule

// ==== rtl/test_ram.sv ====
module test_ram import sonata_pkg::*; (
    input  logic                  mainclk_buf,
    input  logic                  we_i,
    input  logic [MEM_ADDR_W-1:0] addr_i,
    input  logic [MEM_DATA_W-1:0] wdata_i,
    output logic [MEM_DATA_W-1:0] rdata_o
);

    logic [MEM_DATA_W-1:0] mem [2**MEM_ADDR_W];

    // single port, read returns the old word on a write
    always_ff @(posedge mainclk_buf) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
        rdata_o <= mem[addr_i];
    end

endmodule

// ==== rtl/sonata_pkg.sv ====
package sonata_pkg;

    // bus and memory widths
    localparam int REG_ADDR_W   = 8;
    localparam int REG_DATA_W   = 8;
    localparam int MEM_ADDR_W   = 8;   // 256 words
    localparam int MEM_DATA_W   = 16;
    localparam int ERR_CNT_W    = 8;
    localparam int LED_W        = 8;
    localparam int STATUS_LED_W = 4;   // legacy, cheri, halted, bootok
    localparam int HEARTBEAT_W  = 25;

    // pattern generator
    localparam logic [MEM_DATA_W-1:0] LFSR_SEED = 16'hACE1;
    localparam logic [MEM_DATA_W-1:0] LFSR_TAPS = 16'h002D;

    typedef enum logic [REG_ADDR_W-1:0] {
        REG_LED_CTRL     = 8'h00,
        REG_TEST_LEDS    = 8'h01,
        REG_TEST_STATUS  = 8'h02,
        REG_SWITCHES     = 8'h03,
        REG_MT_CTRL      = 8'h04,
        REG_MT_START     = 8'h05,
        REG_MT_STOP      = 8'h06,
        REG_MT_STATUS    = 8'h07,
        REG_MT_ERRORS    = 8'h08,
        REG_MT_ERR_ADDR  = 8'h09,
        REG_MAN_ADDR     = 8'h0A,
        REG_MAN_WDATA_LO = 8'h0B,
        REG_MAN_WDATA_HI = 8'h0C
    } reg_addr_e;

    // REG_LED_CTRL
    localparam int LED_TEST_BIT  = 0;
    localparam int LED_FLASH_BIT = 1;
    localparam int LED_USER_BIT  = 2;

    // REG_MT_CTRL, start and clear are self-clearing
    localparam int MT_START_BIT  = 0;
    localparam int MT_CHECK_BIT  = 1;
    localparam int MT_LFSR_BIT   = 2;
    localparam int MT_CLEAR_BIT  = 3;
    localparam int MT_MANUAL_BIT = 4;

    // REG_MT_STATUS
    localparam int ST_PASS_BIT = 0;
    localparam int ST_FAIL_BIT = 1;
    localparam int ST_IDLE_BIT = 2;

    typedef enum logic [1:0] {
        MT_IDLE,
        MT_WRITE,
        MT_READ,
        MT_DONE
    } mt_state_e;

endpackage
